//--- src/textEditorPkg.sv
package textEditorPkg;

	// Geometry ------------------------------------------------------------
	localparam int charDim   = 16;	// Glyph edge in pixels
	localparam int charScale = 2;	// Pixel replication
	localparam int ramDepth  = 512;	// Text cells
	localparam int rowLength = 18;	// Cells per text row
	localparam int addrW     = 9;	// Cell address width

	typedef logic [7:0] keyCode_t;	// PS/2 scan code

	// Scan codes ----------------------------------------------------------
	localparam keyCode_t codeSpace     = 8'h29;	// Also the blank cell
	localparam keyCode_t codeBackspace = 8'h66;
	localparam keyCode_t codeDelete    = 8'h71;
	localparam keyCode_t codeLeft      = 8'h6B;
	localparam keyCode_t codeRight     = 8'h74;
	localparam keyCode_t codeUp        = 8'h75;
	localparam keyCode_t codeDown      = 8'h72;
	localparam keyCode_t codeBlock     = 8'h70;
	localparam keyCode_t codePeriod    = 8'h49;
	localparam keyCode_t codeA = 8'h1C, codeB = 8'h32, codeC = 8'h21, codeD = 8'h23;
	localparam keyCode_t codeE = 8'h24, codeF = 8'h2B, codeG = 8'h34, codeH = 8'h33;

	typedef enum logic [2:0] {opInsert, opBackspace, opDelete, opLeft, opRight, opUp, opDown}
		editOp_e;
	typedef enum logic [1:0] {stGetKey, stEdit, stWrite} editState_e;

	typedef struct packed {
		logic     valid;	// One-cycle pulse
		editOp_e  op;
		keyCode_t code;
	} keyEvent_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       visible;	// Inside 640x480
	} rasterPos_t;

	typedef struct packed {
		logic red;
		logic green;
		logic blue;
	} rgb_t;

	// Glyph table ---------------------------------------------------------
	// Bit 0 is the top-left pixel and rows of 16 run left to right
	function automatic logic [0:255] glyphOf(input keyCode_t code);
		unique case (code)
			codeBlock:  return {64{4'hF}};
			codePeriod: return 256'h0000000000000000000000000000000000000000000000000000E000E000E000;
			codeA: return 256'h00001FE03870387070387038E01CE01CE01CFFFCFFFCE01CE01CE01CE01CE01C;
			codeB: return 256'h0000FFC0FFF0F078F03CF03CF038FFE0FFE0F038F03CF03CF03CF07CFFF8FFE0;
			codeC: return 256'h00001FF07FFCF81EF01EE000E000E000E000E000E000E000E01EF01E7FFC1FF0;
			codeD: return 256'h0000FFE0FFF8F03CF01CF00EF00EF00EF00EF00EF00EF00EF01CF03CFFF8FFE0;
			codeE: return 256'h0000FFFEFFFEE000E000E000E000FFFEFFFEE000E000E000E000E000FFFEFFFE;
			codeF: return 256'h0000FFFEFFFEF000F000F000F000FFFEFFFEF000F000F000F000F000F000F000;
			codeG: return 256'h00003FF07FF8F01EE00EC000C000C000C000C07EC07EC00EC00EF01E7FF83FF0;
			codeH: return 256'h0000E00EE00EE00EE00EE00EE00EFFFEFFFEE00EE00EE00EE00EE00EE00EE00E;
			default: return '0;	// Everything else is blank
		endcase
	endfunction

endpackage

//--- src/keyDecoder.sv
`timescale 1ns/1ps

module keyDecoder import textEditorPkg::*; (
	input  logic       VGA_clk,
	input  logic       Reset,
	input  keyCode_t   keyCode,
	input  logic       keyReleased,
	output keyEvent_t  keyEvent
);

	logic [1:0] busyCount;	// Cycles left in the busy window
	logic       eventValid;
	editOp_e    eventOp;
	keyCode_t   eventCode;
	logic       accept;

	assign accept = keyReleased && (busyCount == 2'd0);	// Pulses while busy are dropped

	always_ff @(posedge VGA_clk or posedge Reset) begin
		if (Reset) begin
			busyCount  <= 2'd0;
			eventValid <= 1'b0;
		end else begin
			eventValid <= accept;
			if (accept)
				busyCount <= 2'd3;	// Controller needs GETKEY, EDIT, WRITE
			else if (busyCount != 2'd0)
				busyCount <= busyCount - 2'd1;
		end
	end

	// Classify on the sampling edge
	always_ff @(posedge VGA_clk) begin
		if (accept) begin
			eventCode <= keyCode;
			unique case (keyCode)
				codeBackspace: eventOp <= opBackspace;
				codeDelete:    eventOp <= opDelete;
				codeLeft:      eventOp <= opLeft;
				codeRight:     eventOp <= opRight;
				codeUp:        eventOp <= opUp;
				codeDown:      eventOp <= opDown;
				default:       eventOp <= opInsert;	// Any printable or unknown key
			endcase
		end
	end

	assign keyEvent = '{valid: eventValid, op: eventOp, code: eventCode};

endmodule

//--- src/editController.sv
`timescale 1ns/1ps

module editController import textEditorPkg::*; #(
	parameter int ramDepth  = textEditorPkg::ramDepth,
	parameter int rowLength = textEditorPkg::rowLength
) (
	input  logic             VGA_clk,
	input  logic             Reset,
	input  keyEvent_t        keyEvent,
	output logic             ramWrite,
	output logic [addrW-1:0] writeAddr,
	output keyCode_t         writeData,
	output logic [addrW-1:0] cursorPos
);

	localparam logic [addrW-1:0] writeLimit = addrW'(ramDepth - 2);	// Last cell is kept empty
	localparam logic [addrW-1:0] rowStep    = addrW'(rowLength);

	editState_e state;
	editOp_e    curOp;	// Operation latched in GETKEY
	keyCode_t   curCode;

	// Control path --------------------------------------------------------
	always_ff @(posedge VGA_clk or posedge Reset) begin
		if (Reset) begin
			state     <= stGetKey;
			cursorPos <= '0;
			ramWrite  <= 1'b0;
		end else begin
			unique case (state)
				stGetKey: begin
					ramWrite <= 1'b0;
					if (keyEvent.valid)
						state <= stEdit;
				end
				stEdit: begin
					state    <= stWrite;
					ramWrite <= (curOp == opInsert) || (curOp == opBackspace) ||
						(curOp == opDelete);	// Arrows never write
					unique case (curOp)
						opInsert: if (cursorPos < writeLimit) cursorPos <= cursorPos + 1'b1;
						opBackspace, opLeft: begin
							if (cursorPos > '0)
								cursorPos <= cursorPos - 1'b1;
						end
						opDelete: ;	// Cursor stays put
						opRight: if (cursorPos < writeLimit) cursorPos <= cursorPos + 1'b1;
						opUp: if (cursorPos >= rowStep) cursorPos <= cursorPos - rowStep;
						opDown: begin
							if (cursorPos <= writeLimit - rowStep)
								cursorPos <= cursorPos + rowStep;
						end
						default: ;
					endcase
				end
				stWrite: begin
					state    <= stGetKey;
					ramWrite <= 1'b0;	// Single-cycle strobe
				end
				default: state <= stGetKey;
			endcase
		end
	end

	// Key latch and write payload -----------------------------------------
	always_ff @(posedge VGA_clk) begin
		if (state == stGetKey && keyEvent.valid) begin
			curOp   <= keyEvent.op;
			curCode <= keyEvent.code;
		end
		if (state == stEdit) begin
			writeAddr <= cursorPos;
			writeData <= curCode;
			unique case (curOp)
				opBackspace: begin
					writeData <= codeSpace;	// Erase the previous cell
					if (cursorPos > '0)
						writeAddr <= cursorPos - 1'b1;
				end
				opDelete: writeData <= codeSpace;
				default: ;
			endcase
		end
	end

endmodule

//--- src/textRam.sv
`timescale 1ns/1ps

module textRam import textEditorPkg::*; #(
	parameter int ramDepth = textEditorPkg::ramDepth
) (
	input  logic             VGA_clk,
	input  logic             Reset,
	input  logic             ramWrite,
	input  logic [addrW-1:0] writeAddr,
	input  keyCode_t         writeData,
	input  logic [addrW-1:0] readAddr,
	output keyCode_t         readData
);

	keyCode_t mem [ramDepth];	// One scan code per cell

	// Blank document on reset
	always_ff @(posedge VGA_clk or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < ramDepth; i++)
				mem[i] <= codeSpace;
		end else if (ramWrite) begin
			mem[writeAddr] <= writeData;
		end
	end

	// Registered read port for the renderer
	always_ff @(posedge VGA_clk) begin
		readData <= mem[readAddr];
	end

endmodule

//--- src/vgaTiming.sv
`timescale 1ns/1ps

module vgaTiming import textEditorPkg::*; (
	input  logic       VGA_clk,
	input  logic       Reset,
	output rasterPos_t pos,
	output logic       hSync,
	output logic       vSync
);

	// Horizontal line
	localparam int hVisible = 640;
	localparam int hFront   = 16;
	localparam int hSyncLen = 96;
	localparam int hBack    = 48;
	localparam int hTotal   = hVisible + hFront + hSyncLen + hBack;	// 800
	// Vertical frame
	localparam int vVisible = 480;
	localparam int vFront   = 10;
	localparam int vSyncLen = 2;
	localparam int vBack    = 33;
	localparam int vTotal   = vVisible + vFront + vSyncLen + vBack;	// 525

	logic [9:0] hCount;
	logic [9:0] vCount;
	logic       hSyncRaw;
	logic       vSyncRaw;
	logic [1:0] hSyncPipe;	// Matches renderer depth
	logic [1:0] vSyncPipe;

	always_ff @(posedge VGA_clk or posedge Reset) begin
		if (Reset) begin
			hCount    <= '0;
			vCount    <= '0;
			hSyncPipe <= 2'b11;	// Inactive high
			vSyncPipe <= 2'b11;
		end else begin
			hSyncPipe <= {hSyncPipe[0], hSyncRaw};
			vSyncPipe <= {vSyncPipe[0], vSyncRaw};
			if (hCount == 10'(hTotal - 1)) begin
				hCount <= '0;
				vCount <= (vCount == 10'(vTotal - 1)) ? '0 : vCount + 1'b1;	// Frame wrap
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	assign hSyncRaw = !(hCount >= 10'(hVisible + hFront) &&
		hCount < 10'(hVisible + hFront + hSyncLen));	// Active low
	assign vSyncRaw = !(vCount >= 10'(vVisible + vFront) &&
		vCount < 10'(vVisible + vFront + vSyncLen));

	assign pos   = '{x: hCount, y: vCount,
		visible: (hCount < 10'(hVisible)) && (vCount < 10'(vVisible))};
	assign hSync = hSyncPipe[1];
	assign vSync = vSyncPipe[1];

endmodule

//--- src/charRenderer.sv
`timescale 1ns/1ps

module charRenderer import textEditorPkg::*; #(
	parameter int ramDepth  = textEditorPkg::ramDepth,
	parameter int rowLength = textEditorPkg::rowLength
) (
	input  logic             VGA_clk,
	input  logic             Reset,
	input  rasterPos_t       pos,
	input  keyCode_t         readData,
	input  logic [addrW-1:0] cursorPos,
	output logic [addrW-1:0] readAddr,
	output rgb_t             pixel
);

	localparam logic [15:0] lastCell  = 16'(ramDepth - 1);
	localparam logic [9:0]  textWidth = 10'(charDim * rowLength);	// Scaled x limit

	logic [9:0]  xDiv;	// Position in glyph pixels
	logic [9:0]  yDiv;
	logic [9:0]  colIdx;	// Cell column
	logic [9:0]  rowIdx;	// Cell row
	logic [15:0] cellIndex;
	logic [3:0]  glyphX;
	logic [3:0]  glyphY;
	logic [7:0]  glyphIdx;
	logic        cursorHit;
	logic [0:255] glyphBits;

	// Stage 1 side pipeline beside the RAM read
	logic       visibleQ;
	logic       inTextQ;
	logic [7:0] glyphIdxQ;
	logic       cursorHitQ;

	// Cell addressing -----------------------------------------------------
	assign xDiv      = 10'(pos.x / charScale);
	assign yDiv      = 10'(pos.y / charScale);
	assign colIdx    = 10'(xDiv / charDim);
	assign rowIdx    = 10'(yDiv / charDim);
	assign glyphX    = 4'(xDiv % charDim);
	assign glyphY    = 4'(yDiv % charDim);
	assign glyphIdx  = {glyphY, glyphX};	// Row-major index into the pattern
	assign cellIndex = 16'(rowIdx) * 16'(rowLength) + 16'(colIdx);
	assign readAddr  = (cellIndex > lastCell) ? addrW'(lastCell) : addrW'(cellIndex);	// Clamp

	// Cursor bar covers the two left glyph columns
	assign cursorHit = (readAddr == cursorPos) && (glyphX < 4'd2);

	always_ff @(posedge VGA_clk or posedge Reset) begin
		if (Reset) begin
			visibleQ   <= 1'b0;
			inTextQ    <= 1'b0;
			cursorHitQ <= 1'b0;
		end else begin
			visibleQ   <= pos.visible;
			inTextQ    <= xDiv < textWidth;
			cursorHitQ <= cursorHit;
		end
	end

	always_ff @(posedge VGA_clk) begin
		glyphIdxQ <= glyphIdx;
	end

	// Colour stage --------------------------------------------------------
	assign glyphBits = glyphOf(readData);

	always_ff @(posedge VGA_clk or posedge Reset) begin
		if (Reset)
			pixel <= '0;
		else if (!visibleQ)
			pixel <= '0;	// Blanking
		else if (!inTextQ)
			pixel <= '{red: 1'b1, green: 1'b1, blue: 1'b1};	// Right margin
		else if (cursorHitQ)
			pixel <= '{red: 1'b0, green: 1'b1, blue: 1'b0};
		else if (glyphBits[glyphIdxQ])
			pixel <= '{red: 1'b1, green: 1'b0, blue: 1'b1};	// Green text inverted
		else
			pixel <= '{red: 1'b1, green: 1'b1, blue: 1'b1};	// Paper
	end

endmodule

//--- src/textEditorTop.sv
`timescale 1ns/1ps

module textEditorTop import textEditorPkg::*; #(
	parameter int ramDepth  = textEditorPkg::ramDepth,
	parameter int rowLength = textEditorPkg::rowLength
) (
	input  logic             VGA_clk,
	input  logic             Reset,
	input  keyCode_t         keyCode,
	input  logic             keyReleased,	// One-cycle pulse
	output logic             hSync,
	output logic             vSync,
	output rgb_t             pixel,
	output logic [addrW-1:0] cursorPos
);

	keyEvent_t        keyEvent;
	logic             ramWrite;
	logic [addrW-1:0] writeAddr;
	keyCode_t         writeData;
	logic [addrW-1:0] readAddr;
	keyCode_t         readData;
	rasterPos_t       pos;

	// Input and edit side -------------------------------------------------
	keyDecoder keyDecoder_i (.VGA_clk, .Reset, .keyCode, .keyReleased, .keyEvent);

	editController #(.ramDepth(ramDepth), .rowLength(rowLength)) editController_i (
		.VGA_clk, .Reset, .keyEvent, .ramWrite, .writeAddr, .writeData, .cursorPos);

	textRam #(.ramDepth(ramDepth)) textRam_i (
		.VGA_clk, .Reset, .ramWrite, .writeAddr, .writeData, .readAddr, .readData);

	// Display side --------------------------------------------------------
	vgaTiming vgaTiming_i (.VGA_clk, .Reset, .pos, .hSync, .vSync);

	charRenderer #(.ramDepth(ramDepth), .rowLength(rowLength)) charRenderer_i (
		.VGA_clk, .Reset, .pos, .readData, .cursorPos, .readAddr, .pixel);

endmodule

//--- verif/textEditor_assertions.sv
`timescale 1ns/1ps

module textEditor_assertions import textEditorPkg::*; (
	input logic             VGA_clk,
	input logic             Reset,
	input keyCode_t         keyCode,
	input logic             keyReleased,
	input logic             hSync,
	input logic             vSync,
	input rgb_t             pixel,
	input logic [addrW-1:0] cursorPos
);

	localparam logic [addrW-1:0] lastPos = addrW'(ramDepth - 2);	// Cursor ceiling 510
	localparam logic [addrW-1:0] rowStep = addrW'(rowLength);

	int unsigned      failCount = 0;	// Watched by the testbench
	string            failName;
	logic [31:0]      failGot;
	logic [31:0]      failExp;
	logic             hSyncQ;
	logic             vSyncQ;
	logic             hSeen;	// Column tracking valid
	logic             vSeen;	// Line tracking valid
	logic [9:0]       col;	// Column of the pixel now on the port
	logic [9:0]       line;
	logic [19:0]      hSinceFall;
	logic [19:0]      vSinceFall;
	logic [1:0]       busy;	// Key busy window
	logic [3:0]       quiet;	// Cycles since the last accepted key
	logic [2:0]       acceptPipe;
	logic [addrW-1:0] expPipe [3];
	logic [addrW-1:0] cursorQ;
	logic [addrW-1:0] expCursor;	// Cursor by the edit rules
	logic [addrW-1:0] nextCursor;
	keyCode_t         cell0;	// Content of cell 0 by the edit rules
	logic             accepted;
	logic             checkPixel;
	rgb_t             expPixel;

	task automatic noteFailure(input string name, input logic [31:0] got, input logic [31:0] exp);
		failName  = name;
		failGot   = got;
		failExp   = exp;
		failCount++;
	endtask

	// Raster and key tracking ---------------------------------------------
	assign accepted = keyReleased && (busy == 2'd0);

	always_comb begin
		nextCursor = expCursor;
		case (keyCode)
			codeLeft, codeBackspace: if (expCursor != '0) nextCursor = expCursor - 1'b1;
			codeDelete: ;	// Stays put
			codeUp: if (expCursor >= rowStep) nextCursor = expCursor - rowStep;
			codeDown: if (expCursor <= lastPos - rowStep) nextCursor = expCursor + rowStep;
			default: if (expCursor < lastPos) nextCursor = expCursor + 1'b1;	// Right, inserts
		endcase
	end

	always_ff @(posedge VGA_clk or posedge Reset) begin
		if (Reset) begin
			hSyncQ <= 1'b1;
			vSyncQ <= 1'b1;
			hSeen <= 1'b0;
			vSeen <= 1'b0;
			col <= '0;
			line <= '0;
			hSinceFall <= '0;
			vSinceFall <= '0;
			busy <= '0;
			quiet <= 4'd15;
			acceptPipe <= '0;
			cursorQ <= '0;
			expCursor <= '0;
			cell0 <= codeSpace;	// Blank document
		end else begin
			hSyncQ <= hSync;
			vSyncQ <= vSync;
			hSinceFall <= (hSyncQ && !hSync) ? 20'd1 : hSinceFall + 1'b1;
			vSinceFall <= (vSyncQ && !vSync) ? 20'd1 : vSinceFall + 1'b1;
			if (!hSyncQ && hSync) begin
				hSeen <= 1'b1;
				col <= 10'd753;	// Column 0 comes 48 cycles after the rise
			end else begin
				col <= (col == 10'd799) ? '0 : col + 1'b1;
			end
			if (!vSyncQ && vSync) begin
				vSeen <= 1'b1;
				line <= 10'd492;	// First back porch line
			end else if (col == 10'd799) begin
				line <= (line == 10'd524) ? '0 : line + 1'b1;
			end
			busy <= accepted ? 2'd3 : ((busy != 2'd0) ? busy - 1'b1 : busy);
			quiet <= accepted ? 4'd0 : ((quiet == 4'd15) ? quiet : quiet + 1'b1);
			acceptPipe <= {acceptPipe[1:0], accepted};
			expPipe <= '{nextCursor, expPipe[0], expPipe[1]};
			cursorQ <= cursorPos;
			if (accepted) begin
				expCursor <= nextCursor;
				case (keyCode)
					codeBackspace: if (expCursor <= 1) cell0 <= codeSpace;
					codeDelete: if (expCursor == '0) cell0 <= codeSpace;
					codeLeft, codeRight, codeUp, codeDown: ;
					default: if (expCursor == '0) cell0 <= keyCode;
				endcase
			end
		end
	end

	// Expected colour where it is known
	always_comb begin
		checkPixel = 1'b0;
		expPixel = '{red: 1'b1, green: 1'b1, blue: 1'b1};
		if (!vSeen) begin
			checkPixel = 1'b0;
		end else if (col >= 10'd640 || line >= 10'd480) begin
			checkPixel = 1'b1;
			expPixel = '0;	// Blanking
		end else if (col >= 10'd576) begin
			checkPixel = 1'b1;	// Right margin
		end else if (col < 10'd32 && line < 10'd32 && quiet >= 4'd10) begin
			if (expCursor == '0 && col < 10'd4) begin
				checkPixel = 1'b1;
				expPixel = '{red: 1'b0, green: 1'b1, blue: 1'b0};
			end else if (cell0 == codeSpace) begin
				checkPixel = 1'b1;
			end else if (cell0 == codeBlock) begin
				checkPixel = 1'b1;
				expPixel = '{red: 1'b1, green: 1'b0, blue: 1'b1};
			end
		end
	end

	// Sync widths and periods ---------------------------------------------
	hSyncWidth: assert property (@(posedge VGA_clk) disable iff (Reset)
		hSeen && !hSyncQ && hSync |-> hSinceFall == 20'd96)
		else begin
			noteFailure("hSync low width", $sampled(hSinceFall), 96);
			$error("hSync low width");
		end
	hSyncPeriod: assert property (@(posedge VGA_clk) disable iff (Reset)
		hSeen && hSyncQ && !hSync |-> hSinceFall == 20'd800)
		else begin
			noteFailure("hSync period", $sampled(hSinceFall), 800);
			$error("hSync period");
		end
	vSyncWidth: assert property (@(posedge VGA_clk) disable iff (Reset)
		vSeen && !vSyncQ && vSync |-> vSinceFall == 20'd1600)
		else begin
			noteFailure("vSync low width", $sampled(vSinceFall), 1600);
			$error("vSync low width");
		end
	vSyncPeriod: assert property (@(posedge VGA_clk) disable iff (Reset)
		vSeen && vSyncQ && !vSync |-> vSinceFall == 20'd420000)
		else begin
			noteFailure("vSync period", $sampled(vSinceFall), 420000);
			$error("vSync period");
		end

	// Cursor moves and pixels ---------------------------------------------
	cursorStep: assert property (@(posedge VGA_clk) disable iff (Reset)
		accepted |-> ##3 cursorPos == expPipe[2])
		else begin
			noteFailure("cursorPos", $sampled(cursorPos), $sampled(expPipe[2]));
			$error("cursorPos step");
		end
	cursorOnlyOnKey: assert property (@(posedge VGA_clk) disable iff (Reset)
		cursorPos != cursorQ |-> acceptPipe[2])
		else begin
			noteFailure("cursorPos", $sampled(cursorPos), $sampled(cursorQ));
			$error("cursorPos moved without a key");
		end
	pixelColour: assert property (@(posedge VGA_clk) disable iff (Reset)
		checkPixel |-> pixel == expPixel)
		else begin
			noteFailure("pixel", $sampled(pixel), $sampled(expPixel));
			$error("pixel colour");
		end

endmodule

//--- verif/textEditorTb.sv
`timescale 1ns/1ps

module textEditorTb import textEditorPkg::*; ();

	localparam int frameCycles = 800 * 525;
	localparam int slotCycles  = 24;	// Longest key slot
	localparam int timeoutNs   = (3 * frameCycles + 400 * slotCycles) * 100;

	logic             VGA_clk;
	logic             Reset;
	keyCode_t         keyCode;
	logic             keyReleased;
	logic             hSync;
	logic             vSync;
	rgb_t             pixel;
	logic [addrW-1:0] cursorPos;
	keyCode_t         letters [8] = '{codeA, codeB, codeC, codeD, codeE, codeF, codeG, codeH};

	textEditorTop textEditorTop_i (.VGA_clk, .Reset, .keyCode, .keyReleased, .hSync, .vSync,
		.pixel, .cursorPos);

	bind textEditorTop textEditor_assertions checks_i (.*);

	initial begin
		VGA_clk = 1'b0;
		forever #50 VGA_clk = ~VGA_clk;	// 100 ns period
	end

	// Key stimulus --------------------------------------------------------
	task automatic pressKey(input keyCode_t code);
		int gap;
		gap = 8 + ($urandom % 8);
		@(posedge VGA_clk);
		keyCode     <= code;
		keyReleased <= 1'b1;
		@(posedge VGA_clk);
		keyReleased <= 1'b0;
		repeat (gap) @(posedge VGA_clk);
	endtask

	// Three back-to-back pulses where the last two fall in the busy window
	task automatic pressBurst(input keyCode_t code);
		@(posedge VGA_clk);
		keyCode     <= code;
		keyReleased <= 1'b1;
		repeat (3) @(posedge VGA_clk);
		keyReleased <= 1'b0;
		repeat (12) @(posedge VGA_clk);
	endtask

	task automatic waitLine(input int target);
		while (!(textEditorTop_i.checks_i.vSeen && textEditorTop_i.checks_i.line == 10'(target)))
			@(posedge VGA_clk);
	endtask

	initial begin
		void'($urandom(32'h995a_30fa));
		Reset       = 1'b1;
		keyCode     = codeSpace;
		keyReleased = 1'b0;
		repeat (16) @(posedge VGA_clk);
		Reset <= 1'b0;
		waitLine(40);	// Cursor bar over blank cell 0 seen
		pressKey(codeLeft);	// Bounds at 0
		pressKey(codeBackspace);
		pressKey(codeUp);
		pressKey(codeDown);
		pressKey(codeUp);
		pressKey(codeRight);
		pressKey(codeLeft);
		repeat (6) pressKey(letters[$urandom % 8]);
		pressBurst(letters[$urandom % 8]);
		pressKey(codeBackspace);
		pressKey(codeDelete);
		repeat (8) pressKey(codeLeft);	// Back to cell 0
		pressKey(codeBlock);
		pressKey(codeRight);
		waitLine(479);
		waitLine(40);	// Whole block cell rendered
		repeat (28) pressKey(codeDown);
		repeat (6) pressKey(codeRight);	// Saturates at 510
		pressKey(letters[$urandom % 8]);
		pressKey(codeDown);
		repeat (20) @(posedge VGA_clk);
		if (textEditorTop_i.checks_i.failCount == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1, "assertion failures seen");
		end
	end

	// First assertion failure ends the run
	initial begin
		wait (textEditorTop_i.checks_i.failCount != 0);
		$display("MISMATCH %s got 0x%0h expected 0x%0h", textEditorTop_i.checks_i.failName,
			textEditorTop_i.checks_i.failGot, textEditorTop_i.checks_i.failExp);
		$display("Test failed");
		$fatal(1, "assertion failed");
	end

	initial begin
		#(timeoutNs);
		$display("Timeout: the run did not finish in time");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- compile.f
src/textEditorPkg.sv
src/keyDecoder.sv
src/editController.sv
src/textRam.sv
src/vgaTiming.sv
src/charRenderer.sv
src/textEditorTop.sv
verif/textEditor_assertions.sv
verif/textEditorTb.sv

//--- Bender.yml
package:
  name: text_editor

sources:
  - src/textEditorPkg.sv
  - src/keyDecoder.sv
  - src/editController.sv
  - src/textRam.sv
  - src/vgaTiming.sv
  - src/charRenderer.sv
  - src/textEditorTop.sv
  - target: simulation
    files:
      - verif/textEditor_assertions.sv
      - verif/textEditorTb.sv
